// ==== verilog/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    // data or address word
    typedef logic [31:0] word_t;

    // access size, same codes as inst_size/data_size on the core
    typedef logic [1:0] size_t;

    localparam size_t SIZE_BYTE = 2'b00;
    localparam size_t SIZE_HALF = 2'b01;
    localparam size_t SIZE_WORD = 2'b10;

    // top nibble selects the kernel segment
    typedef struct packed {
        logic [3:0]  seg;
        logic [27:0] offset;
    } vaddr_fields_t;

    // one address word, seen flat or as segment plus offset
    typedef union packed {
        word_t         flat;
        vaddr_fields_t f;
    } vaddr_u;

    // axi response code for a good transfer
    localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// ==== verilog/sram_if.sv ====
`default_nettype none

interface sram_if;

    logic              req;
    logic              wr;
    mips_pkg::size_t   size;
    mips_pkg::word_t   addr;
    mips_pkg::word_t   wdata;
    mips_pkg::word_t   rdata;
    logic              addr_ok;
    logic              data_ok;

    // pipeline side
    modport master (
        output req, wr, size, addr, wdata,
        input  rdata, addr_ok, data_ok
    );

    // bridge side
    modport slave (
        input  req, wr, size, addr, wdata,
        output rdata, addr_ok, data_ok
    );

endinterface

`default_nettype wire

// ==== verilog/req_handshake.sv ====
`default_nettype none

module req_handshake (
    input  logic clk,
    input  logic rst_n,
    input  logic cpu_req,
    input  logic addr_ok,
    input  logic data_ok,
    output logic req,
    output logic cpu_data_ok
);

    // high between addr_ok and data_ok
    logic waiting_q;

    // no new request until the previous one has completed
    assign req         = cpu_req && !waiting_q;
    assign cpu_data_ok = waiting_q && data_ok;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            waiting_q <= 1'b0;
        end else if (!waiting_q) begin
            if (req && addr_ok) begin
                waiting_q <= 1'b1;
            end
        end else if (data_ok) begin
            waiting_q <= 1'b0;
        end
    end

    // completion from the bridge only for an accepted request
    a_no_data_ok_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        data_ok |-> waiting_q
    );

    // bridge accepts only what was asked for
    a_addr_ok_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        addr_ok |-> req
    );

endmodule

`default_nettype wire

// ==== verilog/mem_port.sv ====
`default_nettype none

module mem_port #(
    parameter bit MAP_KSEG = 1'b0
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cpu_req,
    input  logic              cpu_wr,
    input  mips_pkg::size_t   cpu_size,
    input  mips_pkg::word_t   cpu_addr,
    input  mips_pkg::word_t   cpu_wdata,
    output mips_pkg::word_t   cpu_rdata,
    output logic              cpu_data_ok,
    sram_if.master            bus
);

    mips_pkg::vaddr_u vaddr;
    mips_pkg::vaddr_u paddr;

    assign vaddr.flat = cpu_addr;

    // kseg0 and kseg1 fold onto the low 512 MB
    always_comb begin
        paddr = vaddr;
        if (MAP_KSEG) begin
            case (vaddr.f.seg)
                4'h8, 4'ha: paddr.f.seg = 4'h0;
                4'h9, 4'hb: paddr.f.seg = 4'h1;
                default:    paddr.f.seg = vaddr.f.seg;
            endcase
        end
    end

    assign bus.wr    = cpu_wr;
    assign bus.size  = cpu_size;
    assign bus.addr  = paddr.flat;
    assign bus.wdata = cpu_wdata;

    assign cpu_rdata = bus.rdata;

    req_handshake u_handshake (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpu_req     (cpu_req),
        .addr_ok     (bus.addr_ok),
        .data_ok     (bus.data_ok),
        .req         (bus.req),
        .cpu_data_ok (cpu_data_ok)
    );

endmodule

`default_nettype wire

// ==== verilog/sram_axi_bridge.sv ====
`default_nettype none

module sram_axi_bridge (
    input  logic              aclk,
    input  logic              rst_n,
    sram_if.slave             inst,
    sram_if.slave             data,

    output mips_pkg::word_t   araddr,
    output logic [2:0]        arsize,
    output logic              arvalid,
    input  logic              arready,

    input  mips_pkg::word_t   rdata,
    input  logic [1:0]        rresp,
    input  logic              rvalid,
    output logic              rready,

    output mips_pkg::word_t   awaddr,
    output logic [2:0]        awsize,
    output logic              awvalid,
    input  logic              awready,

    output mips_pkg::word_t   wdata,
    output logic [3:0]        wstrb,
    output logic              wvalid,
    input  logic              wready,

    input  logic [1:0]        bresp,
    input  logic              bvalid,
    output logic              bready
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_READ  = 2'd1;
    localparam logic [1:0] ST_WRITE = 2'd2;

    logic [1:0]       state_q;
    logic             owner_data_q;
    logic             arvalid_q;
    logic             awvalid_q;
    logic             wvalid_q;
    mips_pkg::word_t  addr_q;
    mips_pkg::size_t  size_q;
    mips_pkg::word_t  wdata_q;
    logic [3:0]       wstrb_q;

    logic             accept;
    logic             sel_wr;
    mips_pkg::size_t  sel_size;
    mips_pkg::word_t  sel_addr;
    logic             r_done;
    logic             b_done;

    // byte lanes from size and the low address bits
    function automatic logic [3:0] lane_strb(mips_pkg::size_t size, logic [1:0] lo);
        case (size)
            mips_pkg::SIZE_BYTE: lane_strb = 4'b0001 << lo;
            mips_pkg::SIZE_HALF: lane_strb = lo[1] ? 4'b1100 : 4'b0011;
            default:             lane_strb = 4'b1111;
        endcase
    endfunction

    // data port has fixed priority
    assign data.addr_ok = (state_q == ST_IDLE) && data.req;
    assign inst.addr_ok = (state_q == ST_IDLE) && inst.req && !data.req;
    assign accept       = data.addr_ok || inst.addr_ok;

    assign sel_wr   = data.req ? data.wr   : inst.wr;
    assign sel_size = data.req ? data.size : inst.size;
    assign sel_addr = data.req ? data.addr : inst.addr;

    assign r_done = rvalid && rready;
    assign b_done = bvalid && bready;

    assign data.data_ok = (r_done || b_done) && owner_data_q;
    assign inst.data_ok = (r_done || b_done) && !owner_data_q;
    assign data.rdata   = rdata;
    assign inst.rdata   = rdata;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state_q      <= ST_IDLE;
            owner_data_q <= 1'b0;
            arvalid_q    <= 1'b0;
            awvalid_q    <= 1'b0;
            wvalid_q     <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        owner_data_q <= data.req;
                        if (sel_wr) begin
                            state_q   <= ST_WRITE;
                            awvalid_q <= 1'b1;
                            wvalid_q  <= 1'b1;
                        end else begin
                            state_q   <= ST_READ;
                            arvalid_q <= 1'b1;
                        end
                    end
                end
                ST_READ: begin
                    if (arready) begin
                        arvalid_q <= 1'b0;
                    end
                    if (r_done) begin
                        state_q <= ST_IDLE;
                    end
                end
                ST_WRITE: begin
                    if (awready) begin
                        awvalid_q <= 1'b0;
                    end
                    if (wready) begin
                        wvalid_q <= 1'b0;
                    end
                    if (b_done) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // request payload, captured on acceptance
    always_ff @(posedge aclk) begin
        if (accept) begin
            addr_q  <= sel_addr;
            size_q  <= sel_size;
            wdata_q <= data.req ? data.wdata : inst.wdata;
            wstrb_q <= lane_strb(sel_size, sel_addr[1:0]);
        end
    end

    assign araddr  = addr_q;
    assign arsize  = {1'b0, size_q};
    assign arvalid = arvalid_q;
    assign rready  = (state_q == ST_READ);

    assign awaddr  = addr_q;
    assign awsize  = {1'b0, size_q};
    assign awvalid = awvalid_q;
    assign wdata   = wdata_q;
    assign wstrb   = wstrb_q;
    assign wvalid  = wvalid_q;
    // response only after both address and data went out
    assign bready  = (state_q == ST_WRITE) && !awvalid_q && !wvalid_q;

    a_ar_hold: assert property (
        @(posedge aclk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr)
    );

    a_aw_hold: assert property (
        @(posedge aclk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr)
    );

    a_w_hold: assert property (
        @(posedge aclk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb)
    );

    // no error path back to the pipeline
    a_resp_okay: assert property (
        @(posedge aclk) disable iff (!rst_n)
        (r_done -> rresp == mips_pkg::RESP_OKAY) && (b_done -> bresp == mips_pkg::RESP_OKAY)
    );

endmodule

`default_nettype wire

// ==== verilog/mem_unit_top.sv ====
`default_nettype none

module mem_unit_top (
    input  logic              aclk,
    input  logic              rst_n,

    input  logic              inst_cpu_req,
    input  mips_pkg::word_t   inst_cpu_addr,
    output mips_pkg::word_t   inst_rdata,
    output logic              inst_data_ok,

    input  logic              data_cpu_req,
    input  logic              data_cpu_wr,
    input  mips_pkg::size_t   data_cpu_size,
    input  mips_pkg::word_t   data_cpu_addr,
    input  mips_pkg::word_t   data_cpu_wdata,
    output mips_pkg::word_t   data_rdata,
    output logic              data_data_ok,

    output mips_pkg::word_t   araddr,
    output logic [2:0]        arsize,
    output logic              arvalid,
    input  logic              arready,
    input  mips_pkg::word_t   rdata,
    input  logic [1:0]        rresp,
    input  logic              rvalid,
    output logic              rready,
    output mips_pkg::word_t   awaddr,
    output logic [2:0]        awsize,
    output logic              awvalid,
    input  logic              awready,
    output mips_pkg::word_t   wdata,
    output logic [3:0]        wstrb,
    output logic              wvalid,
    input  logic              wready,
    input  logic [1:0]        bresp,
    input  logic              bvalid,
    output logic              bready
);

    sram_if inst_bus ();
    sram_if data_bus ();

    // fetch is always a word read
    mem_port #(
        .MAP_KSEG (1'b0)
    ) inst_port (
        .clk         (aclk),
        .rst_n       (rst_n),
        .cpu_req     (inst_cpu_req),
        .cpu_wr      (1'b0),
        .cpu_size    (mips_pkg::SIZE_WORD),
        .cpu_addr    (inst_cpu_addr),
        .cpu_wdata   ('0),
        .cpu_rdata   (inst_rdata),
        .cpu_data_ok (inst_data_ok),
        .bus         (inst_bus.master)
    );

    mem_port #(
        .MAP_KSEG (1'b1)
    ) data_port (
        .clk         (aclk),
        .rst_n       (rst_n),
        .cpu_req     (data_cpu_req),
        .cpu_wr      (data_cpu_wr),
        .cpu_size    (data_cpu_size),
        .cpu_addr    (data_cpu_addr),
        .cpu_wdata   (data_cpu_wdata),
        .cpu_rdata   (data_rdata),
        .cpu_data_ok (data_data_ok),
        .bus         (data_bus.master)
    );

    sram_axi_bridge u_bridge (
        .aclk, .rst_n,
        .inst (inst_bus.slave),
        .data (data_bus.slave),
        .araddr, .arsize, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready,
        .awaddr, .awsize, .awvalid, .awready,
        .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready
    );

endmodule

`default_nettype wire

// ==== sim/axi_slave_model.sv ====
`default_nettype none

module axi_slave_model (
    input  logic              aclk,
    input  logic              rst_n,
    input  mips_pkg::word_t   araddr,
    input  logic [2:0]        arsize,
    input  logic              arvalid,
    output logic              arready = 1'b0,
    output mips_pkg::word_t   rdata = '0,
    output logic [1:0]        rresp = 2'b00,
    output logic              rvalid = 1'b0,
    input  logic              rready,
    input  mips_pkg::word_t   awaddr,
    input  logic [2:0]        awsize,
    input  logic              awvalid,
    output logic              awready = 1'b0,
    input  mips_pkg::word_t   wdata,
    input  logic [3:0]        wstrb,
    input  logic              wvalid,
    output logic              wready = 1'b0,
    output logic [1:0]        bresp = 2'b00,
    output logic              bvalid = 1'b0,
    input  logic              bready,
    output mips_pkg::word_t   last_awaddr = '0,
    output logic [2:0]        last_arsize = '0,
    output logic [2:0]        last_awsize = '0
);
    timeunit 1ns;
    timeprecision 1ps;

    integer           seed = 32'h07e0_40a6;
    logic [1:0]       ar_wait;
    logic [1:0]       r_wait;
    logic [1:0]       aw_wait;
    logic [1:0]       w_wait;
    logic [1:0]       b_wait;
    logic             r_pend;
    logic             aw_got;
    logic             w_got;
    mips_pkg::word_t  r_addr;
    mips_pkg::word_t  w_addr;
    mips_pkg::word_t  w_data;
    logic [3:0]       w_strb;
    mips_pkg::word_t  mem [mips_pkg::word_t];

    // 0 to 3 idle cycles before a ready or valid
    function automatic logic [1:0] next_delay();
        logic [31:0] r;
        r = $random(seed);
        return r[1:0];
    endfunction

    // unwritten words read back as a pattern of their address
    function automatic mips_pkg::word_t read_word(mips_pkg::word_t a);
        mips_pkg::word_t key;
        key = {a[31:2], 2'b00};
        if (mem.exists(key)) begin
            return mem[key];
        end
        return key ^ 32'h3c5a_96e1;
    endfunction

    function automatic mips_pkg::word_t merge_lanes(mips_pkg::word_t old,
                                                    mips_pkg::word_t nw, logic [3:0] strb);
        mips_pkg::word_t res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = nw[8*i +: 8];
            end
        end
        return res;
    endfunction

    always @(posedge aclk) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            r_pend  <= 1'b0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            ar_wait <= 2'd0;
            r_wait  <= 2'd0;
            aw_wait <= 2'd0;
            w_wait  <= 2'd0;
            b_wait  <= 2'd0;
        end else begin
            // read address and read data
            arready <= 1'b0;
            if (arvalid && arready) begin
                r_addr      <= araddr;
                last_arsize <= arsize;
                r_pend      <= 1'b1;
                r_wait      <= next_delay();
                ar_wait     <= next_delay();
            end else if (arvalid && !r_pend) begin
                if (ar_wait == 2'd0) begin
                    arready <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 2'd1;
                end
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                r_pend <= 1'b0;
            end else if (r_pend && !rvalid) begin
                if (r_wait == 2'd0) begin
                    rvalid <= 1'b1;
                    rdata  <= read_word(r_addr);
                end else begin
                    r_wait <= r_wait - 2'd1;
                end
            end

            // write address and write data with separate delays
            awready <= 1'b0;
            if (awvalid && awready) begin
                w_addr      <= awaddr;
                last_awaddr <= awaddr;
                last_awsize <= awsize;
                aw_got      <= 1'b1;
                aw_wait     <= next_delay();
                b_wait      <= next_delay();
            end else if (awvalid && !aw_got) begin
                if (aw_wait == 2'd0) begin
                    awready <= 1'b1;
                end else begin
                    aw_wait <= aw_wait - 2'd1;
                end
            end
            wready <= 1'b0;
            if (wvalid && wready) begin
                w_data <= wdata;
                w_strb <= wstrb;
                w_got  <= 1'b1;
                w_wait <= next_delay();
            end else if (wvalid && !w_got) begin
                if (w_wait == 2'd0) begin
                    wready <= 1'b1;
                end else begin
                    w_wait <= w_wait - 2'd1;
                end
            end

            // response once both halves of the write are in
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                aw_got <= 1'b0;
                w_got  <= 1'b0;
            end else if (aw_got && w_got && !bvalid) begin
                if (b_wait == 2'd0) begin
                    bvalid <= 1'b1;
                    mem[{w_addr[31:2], 2'b00}] = merge_lanes(read_word(w_addr), w_data, w_strb);
                end else begin
                    b_wait <= b_wait - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_mem_unit.sv ====
`default_nettype none

module tb_mem_unit;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int   TIMEOUT  = 40;
    localparam int   NUM_ROWS = 16;
    localparam logic DPORT    = 1'b1;
    localparam logic IPORT    = 1'b0;

    typedef struct packed {
        logic             port;
        logic             wr;
        mips_pkg::size_t  size;
        mips_pkg::word_t  addr;
        mips_pkg::word_t  wdata;
        // rdata for a read, physical awaddr for a write
        mips_pkg::word_t  exp;
    } row_t;

    // byte and half writes carry their data in the addressed lanes
    localparam row_t ROWS [NUM_ROWS] = '{
        '{DPORT, 1'b1, mips_pkg::SIZE_WORD, 32'h0000_0100, 32'h1122_3344, 32'h0000_0100},
        '{DPORT, 1'b0, mips_pkg::SIZE_WORD, 32'h0000_0100, 32'h0000_0000, 32'h1122_3344},
        '{DPORT, 1'b1, mips_pkg::SIZE_BYTE, 32'h0000_0101, 32'h0000_aa00, 32'h0000_0101},
        '{DPORT, 1'b1, mips_pkg::SIZE_HALF, 32'h0000_0102, 32'hbeef_0000, 32'h0000_0102},
        '{DPORT, 1'b1, mips_pkg::SIZE_BYTE, 32'h0000_0103, 32'h5500_0000, 32'h0000_0103},
        '{DPORT, 1'b0, mips_pkg::SIZE_WORD, 32'h0000_0100, 32'h0000_0000, 32'h55ef_aa44},
        '{DPORT, 1'b1, mips_pkg::SIZE_WORD, 32'h8000_0040, 32'hcafe_0040, 32'h0000_0040},
        '{IPORT, 1'b0, mips_pkg::SIZE_WORD, 32'h0000_0040, 32'h0000_0000, 32'hcafe_0040},
        '{DPORT, 1'b1, mips_pkg::SIZE_WORD, 32'hb000_0080, 32'h0bad_f00d, 32'h1000_0080},
        '{DPORT, 1'b0, mips_pkg::SIZE_WORD, 32'h1000_0080, 32'h0000_0000, 32'h0bad_f00d},
        '{DPORT, 1'b1, mips_pkg::SIZE_WORD, 32'ha000_0300, 32'h0f0f_0f0f, 32'h0000_0300},
        '{DPORT, 1'b1, mips_pkg::SIZE_HALF, 32'h8000_0300, 32'h0000_c3c3, 32'h0000_0300},
        '{IPORT, 1'b0, mips_pkg::SIZE_WORD, 32'h0000_0300, 32'h0000_0000, 32'h0f0f_c3c3},
        '{DPORT, 1'b0, mips_pkg::SIZE_WORD, 32'h9000_0080, 32'h0000_0000, 32'h0bad_f00d},
        '{DPORT, 1'b1, mips_pkg::SIZE_BYTE, 32'h1000_0082, 32'h0077_0000, 32'h1000_0082},
        '{DPORT, 1'b0, mips_pkg::SIZE_WORD, 32'hb000_0080, 32'h0000_0000, 32'h0b77_f00d}
    };

    logic aclk;
    logic rst_n;
    logic inst_cpu_req;
    mips_pkg::word_t inst_cpu_addr;
    mips_pkg::word_t inst_rdata;
    logic inst_data_ok;
    logic data_cpu_req;
    logic data_cpu_wr;
    mips_pkg::size_t data_cpu_size;
    mips_pkg::word_t data_cpu_addr;
    mips_pkg::word_t data_cpu_wdata;
    mips_pkg::word_t data_rdata;
    logic data_data_ok;
    mips_pkg::word_t araddr;
    logic [2:0] arsize;
    logic arvalid;
    logic arready;
    mips_pkg::word_t rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready;
    mips_pkg::word_t awaddr;
    logic [2:0] awsize;
    logic awvalid;
    logic awready;
    mips_pkg::word_t wdata;
    logic [3:0] wstrb;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    mips_pkg::word_t last_awaddr;
    logic [2:0] last_arsize;
    logic [2:0] last_awsize;

    mem_unit_top dut (.*);

    axi_slave_model u_slave (.*);

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    task automatic check_value(input string name, input mips_pkg::word_t actual,
                               input mips_pkg::word_t expected);
        if (actual !== expected) begin
            $display("FAIL %s: got %h, expected %h", name, actual, expected);
            $display("Verification failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "run aborted");
    endtask

    // axi size field is log2 of the bytes per beat
    function automatic logic [2:0] axi_size_of(input mips_pkg::size_t s);
        int nbytes;
        case (s)
            mips_pkg::SIZE_BYTE: nbytes = 1;
            mips_pkg::SIZE_HALF: nbytes = 2;
            default:             nbytes = 4;
        endcase
        return 3'($clog2(nbytes));
    endfunction

    task automatic check_outputs_idle();
        check_value("arvalid", {31'd0, arvalid}, 32'd0);
        check_value("awvalid", {31'd0, awvalid}, 32'd0);
        check_value("wvalid", {31'd0, wvalid}, 32'd0);
        check_value("inst_data_ok", {31'd0, inst_data_ok}, 32'd0);
        check_value("data_data_ok", {31'd0, data_data_ok}, 32'd0);
    endtask

    task automatic drive_request(input row_t r);
        @(posedge aclk);
        #1;
        if (r.port) begin
            data_cpu_req   = 1'b1;
            data_cpu_wr    = r.wr;
            data_cpu_size  = r.size;
            data_cpu_addr  = r.addr;
            data_cpu_wdata = r.wdata;
        end else begin
            inst_cpu_req  = 1'b1;
            inst_cpu_addr = r.addr;
        end
    endtask

    // sample at the falling edge where the completion pulse is stable
    task automatic wait_done(input logic port, output mips_pkg::word_t rd);
        int n;
        for (n = 0; n < TIMEOUT; n++) begin
            @(negedge aclk);
            if (port ? data_data_ok : inst_data_ok) begin
                break;
            end
        end
        if (n == TIMEOUT) begin
            abort_run(port ? "data port request did not complete in time"
                           : "instruction port request did not complete in time");
        end else begin
            rd = port ? data_rdata : inst_rdata;
        end
    endtask

    task automatic release_request(input logic port);
        @(posedge aclk);
        #1;
        if (port) begin
            data_cpu_req = 1'b0;
        end else begin
            inst_cpu_req = 1'b0;
        end
    endtask

    task automatic run_row(input int idx, input row_t r);
        mips_pkg::word_t rd;
        mips_pkg::size_t sz;
        // fetches are always word reads
        sz = r.port ? r.size : mips_pkg::SIZE_WORD;
        drive_request(r);
        wait_done(r.port, rd);
        release_request(r.port);
        if (r.wr) begin
            check_value($sformatf("awaddr (row %0d)", idx), last_awaddr, r.exp);
            check_value($sformatf("awsize (row %0d)", idx), {29'd0, last_awsize},
                        {29'd0, axi_size_of(sz)});
        end else begin
            check_value($sformatf("arsize (row %0d)", idx), {29'd0, last_arsize},
                        {29'd0, axi_size_of(sz)});
            if (r.port) begin
                check_value($sformatf("data_rdata (row %0d)", idx), rd, r.exp);
            end else begin
                check_value($sformatf("inst_rdata (row %0d)", idx), rd, r.exp);
            end
        end
    endtask

    // both ports in one cycle where the data port wins
    task automatic run_both_ports();
        int n;
        logic got_d;
        logic got_i;
        logic data_first;
        mips_pkg::word_t d_rd;
        mips_pkg::word_t i_rd;
        got_d = 1'b0;
        got_i = 1'b0;
        data_first = 1'b0;
        @(posedge aclk);
        #1;
        data_cpu_req  = 1'b1;
        data_cpu_wr   = 1'b0;
        data_cpu_size = mips_pkg::SIZE_WORD;
        data_cpu_addr = 32'h0000_0100;
        inst_cpu_req  = 1'b1;
        inst_cpu_addr = 32'h0000_0300;
        for (n = 0; n < 2 * TIMEOUT && !(got_d && got_i); n++) begin
            @(negedge aclk);
            if (data_data_ok) begin
                got_d = 1'b1;
                d_rd = data_rdata;
                data_first = !got_i;
            end
            if (inst_data_ok) begin
                got_i = 1'b1;
                i_rd = inst_rdata;
            end
            @(posedge aclk);
            #1;
            if (got_d) begin
                data_cpu_req = 1'b0;
            end
            if (got_i) begin
                inst_cpu_req = 1'b0;
            end
        end
        if (!(got_d && got_i)) begin
            abort_run("simultaneous requests did not both complete in time");
        end else begin
            check_value("data_data_ok first", {31'd0, data_first}, 32'd1);
            check_value("data_rdata", d_rd, 32'h55ef_aa44);
            check_value("inst_rdata", i_rd, 32'h0f0f_c3c3);
        end
    endtask

    initial begin
        rst_n          = 1'b0;
        inst_cpu_req   = 1'b0;
        inst_cpu_addr  = '0;
        data_cpu_req   = 1'b0;
        data_cpu_wr    = 1'b0;
        data_cpu_size  = mips_pkg::SIZE_WORD;
        data_cpu_addr  = '0;
        data_cpu_wdata = '0;

        repeat (4) begin
            @(posedge aclk);
            #1;
            check_outputs_idle();
        end
        rst_n = 1'b1;
        @(negedge aclk);
        check_outputs_idle();

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i, ROWS[i]);
        end
        run_both_ports();

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
verilog/mips_pkg.sv
verilog/sram_if.sv
verilog/req_handshake.sv
verilog/mem_port.sv
verilog/sram_axi_bridge.sv
verilog/mem_unit_top.sv
sim/axi_slave_model.sv
sim/tb_mem_unit.sv

// ==== Bender.yml ====
package:
  name: mem_unit

sources:
  - verilog/mips_pkg.sv
  - verilog/sram_if.sv
  - verilog/req_handshake.sv
  - verilog/mem_port.sv
  - verilog/sram_axi_bridge.sv
  - verilog/mem_unit_top.sv
  - target: simulation
    files:
      - sim/axi_slave_model.sv
      - sim/tb_mem_unit.sv
